//--- source/rob_pkg.sv
package rob_pkg;

    localparam int xlen         = 32;
    localparam int reg_bits     = 5;
    localparam int max_tag_bits = 4;

    typedef enum logic [1:0] {
        kind_alu    = 2'd0,
        kind_branch = 2'd1,
        kind_store  = 2'd2
    } op_kind_t;

    // from the front end at allocation
    typedef struct packed {
        logic [reg_bits-1:0] rd;
        op_kind_t            kind;
        logic                pred_taken;
    } alloc_req_t;

    // one-cycle completion report from execute
    typedef struct packed {
        logic                    valid;
        logic [max_tag_bits-1:0] tag;
        logic [xlen-1:0]         data;
        logic                    taken;
        logic [xlen-1:0]         target;
    } exec_result_t;

    typedef struct packed {
        logic                    valid;
        logic [reg_bits-1:0]     rd;
        logic [xlen-1:0]         data;
        logic [max_tag_bits-1:0] tag;
    } retire_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
    } redirect_t;

    // head entry as seen by the commit logic
    typedef struct packed {
        logic                occupied;
        logic                done;
        op_kind_t            kind;
        logic                pred_taken;
        logic                taken;
        logic [reg_bits-1:0] rd;
        logic [xlen-1:0]     data;
        logic [xlen-1:0]     target;
    } rob_entry_t;

endpackage

//--- source/rob_table.sv
`timescale 1ns/1ps

module rob_table #(
    parameter int rob_depth = 16
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                alloc_en,
    input  rob_pkg::alloc_req_t                 alloc,
    output logic                                alloc_grant,
    output logic [rob_pkg::max_tag_bits-1:0]    alloc_tag,
    output logic                                full,
    input  rob_pkg::exec_result_t               exec,
    output rob_pkg::rob_entry_t                 head,
    output logic [rob_pkg::max_tag_bits-1:0]    head_tag,
    input  logic                                retire_en,
    input  logic                                flush
);

    localparam int tag_bits = rob_pkg::max_tag_bits;
    localparam int cnt_bits = rob_pkg::max_tag_bits + 1;
    localparam logic [tag_bits-1:0] last_idx    = tag_bits'(rob_depth - 1);
    localparam logic [cnt_bits-1:0] depth_count = cnt_bits'(rob_depth);

    // control state
    logic [rob_depth-1:0] occupied;
    logic [rob_depth-1:0] done;
    logic [tag_bits-1:0]  head_ptr;
    logic [tag_bits-1:0]  tail_ptr;
    logic [cnt_bits-1:0]  count;

    // payload, qualified by occupied/done
    rob_pkg::op_kind_t          kind_mem   [rob_depth];
    logic                       pred_mem   [rob_depth];
    logic                       taken_mem  [rob_depth];
    logic [rob_pkg::reg_bits-1:0] rd_mem   [rob_depth];
    logic [rob_pkg::xlen-1:0]   data_mem   [rob_depth];
    logic [rob_pkg::xlen-1:0]   target_mem [rob_depth];

    logic [tag_bits-1:0] head_next;
    logic [tag_bits-1:0] tail_next;

    assign head_next = (head_ptr == last_idx) ? '0 : head_ptr + 1'b1;
    assign tail_next = (tail_ptr == last_idx) ? '0 : tail_ptr + 1'b1;

    assign full        = (count == depth_count);
    assign alloc_grant = alloc_en && !full && !flush;
    assign alloc_tag   = tail_ptr;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            occupied <= '0;
            done     <= '0;
            head_ptr <= '0;
            tail_ptr <= '0;
            count    <= '0;
        end else if (flush) begin
            // mispredict drops every younger entry
            occupied <= '0;
            done     <= '0;
            head_ptr <= '0;
            tail_ptr <= '0;
            count    <= '0;
        end else begin
            if (exec.valid) begin
                done[exec.tag] <= 1'b1;
            end
            if (retire_en) begin
                occupied[head_ptr] <= 1'b0;
                done[head_ptr]     <= 1'b0;
                head_ptr           <= head_next;
            end
            if (alloc_grant) begin
                occupied[tail_ptr] <= 1'b1;
                done[tail_ptr]     <= 1'b0;
                tail_ptr           <= tail_next;
            end
            case ({alloc_grant, retire_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_grant) begin
            kind_mem[tail_ptr] <= alloc.kind;
            pred_mem[tail_ptr] <= alloc.pred_taken;
            rd_mem[tail_ptr]   <= alloc.rd;
        end
        if (exec.valid) begin
            data_mem[exec.tag]   <= exec.data;
            taken_mem[exec.tag]  <= exec.taken;
            target_mem[exec.tag] <= exec.target;
        end
    end

    always_comb begin
        head.occupied   = occupied[head_ptr];
        head.done       = done[head_ptr];
        head.kind       = kind_mem[head_ptr];
        head.pred_taken = pred_mem[head_ptr];
        head.taken      = taken_mem[head_ptr];
        head.rd         = rd_mem[head_ptr];
        head.data       = data_mem[head_ptr];
        head.target     = target_mem[head_ptr];
    end

    assign head_tag = head_ptr;

endmodule

//--- source/rob_commit.sv
`timescale 1ns/1ps

module rob_commit (
    input  rob_pkg::rob_entry_t                 head,
    input  logic [rob_pkg::max_tag_bits-1:0]    head_tag,
    input  logic                                store_ack,
    output rob_pkg::retire_t                    retire,
    output logic                                retire_en,
    output rob_pkg::redirect_t                  redirect,
    output logic                                flush,
    output logic                                store_commit,
    output logic [rob_pkg::max_tag_bits-1:0]    store_tag
);

    logic is_store;
    logic is_branch;
    logic mispredict;
    logic normal_retire;
    logic store_retire;

    assign is_store  = (head.kind == rob_pkg::kind_store);
    assign is_branch = (head.kind == rob_pkg::kind_branch);

    // only branches carry a meaningful direction
    assign mispredict = is_branch && (head.pred_taken != head.taken);

    assign normal_retire = head.occupied && head.done && !is_store;

    // store waits at the head for the buffer to take it
    assign store_commit = head.occupied && is_store;
    assign store_tag    = head_tag;
    assign store_retire = store_commit && store_ack;

    assign retire_en = normal_retire || store_retire;
    assign flush     = normal_retire && mispredict;

    always_comb begin
        retire.valid = retire_en;
        retire.rd    = is_store ? '0 : head.rd;
        retire.data  = head.data;
        retire.tag   = head_tag;
    end

    always_comb begin
        redirect.valid = flush;
        redirect.pc    = head.target;
    end

endmodule

//--- source/reg_status.sv
`timescale 1ns/1ps

module reg_status (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                rename_en,
    input  logic [rob_pkg::reg_bits-1:0]        rename_rd,
    input  logic [rob_pkg::max_tag_bits-1:0]    rename_tag,
    input  rob_pkg::retire_t                    retire,
    input  logic                                flush,
    input  logic [rob_pkg::reg_bits-1:0]        query_reg,
    output logic [rob_pkg::xlen-1:0]            query_data,
    output logic                                query_busy,
    output logic [rob_pkg::max_tag_bits-1:0]    query_tag
);

    localparam int num_regs = 1 << rob_pkg::reg_bits;

    logic [rob_pkg::xlen-1:0]         regs     [num_regs];
    logic [rob_pkg::max_tag_bits-1:0] tags     [num_regs];
    logic [num_regs-1:0]              busy;

    logic write_en;
    logic tag_match;
    logic rename_live;

    // x0 is hardwired, never written or renamed
    assign write_en    = retire.valid && (retire.rd != '0);
    assign tag_match   = busy[retire.rd] && (tags[retire.rd] == retire.tag);
    assign rename_live = rename_en && (rename_rd != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= '0;
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
                tags[i] <= '0;
            end
        end else begin
            if (write_en) begin
                regs[retire.rd] <= retire.data;
            end
            if (flush) begin
                busy <= '0;
            end else begin
                // older retire must not clear a newer rename
                if (write_en && tag_match) begin
                    busy[retire.rd] <= 1'b0;
                end
                // rename wins on the same register
                if (rename_live) begin
                    busy[rename_rd] <= 1'b1;
                    tags[rename_rd] <= rename_tag;
                end
            end
        end
    end

    assign query_data = regs[query_reg];
    assign query_busy = busy[query_reg];
    assign query_tag  = tags[query_reg];

endmodule

//--- source/rob_retire_top.sv
`timescale 1ns/1ps

module rob_retire_top #(
    parameter int rob_depth = 16
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                alloc_en,
    input  rob_pkg::alloc_req_t                 alloc,
    output logic                                alloc_grant,
    output logic [rob_pkg::max_tag_bits-1:0]    alloc_tag,
    output logic                                full,
    input  rob_pkg::exec_result_t               exec,
    input  logic                                store_ack,
    output logic                                store_commit,
    output logic [rob_pkg::max_tag_bits-1:0]    store_tag,
    output rob_pkg::retire_t                    retire,
    output rob_pkg::redirect_t                  redirect,
    input  logic [rob_pkg::reg_bits-1:0]        query_reg,
    output logic [rob_pkg::xlen-1:0]            query_data,
    output logic                                query_busy,
    output logic [rob_pkg::max_tag_bits-1:0]    query_tag
);

    rob_pkg::rob_entry_t              head;
    logic [rob_pkg::max_tag_bits-1:0] head_tag;
    logic                             retire_en;
    logic                             flush;

    rob_table #(
        .rob_depth (rob_depth)
    ) rob_table_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .alloc_en    (alloc_en),
        .alloc       (alloc),
        .alloc_grant (alloc_grant),
        .alloc_tag   (alloc_tag),
        .full        (full),
        .exec        (exec),
        .head        (head),
        .head_tag    (head_tag),
        .retire_en   (retire_en),
        .flush       (flush)
    );

    rob_commit rob_commit_inst (
        .head         (head),
        .head_tag     (head_tag),
        .store_ack    (store_ack),
        .retire       (retire),
        .retire_en    (retire_en),
        .redirect     (redirect),
        .flush        (flush),
        .store_commit (store_commit),
        .store_tag    (store_tag)
    );

    // rename straight from the granted allocation
    reg_status reg_status_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .rename_en  (alloc_grant),
        .rename_rd  (alloc.rd),
        .rename_tag (alloc_tag),
        .retire     (retire),
        .flush      (flush),
        .query_reg  (query_reg),
        .query_data (query_data),
        .query_busy (query_busy),
        .query_tag  (query_tag)
    );

endmodule

//--- sim/rob_retire_sva.sv
`timescale 1ns/1ps

module rob_retire_sva (
    input logic                                clk,
    input logic                                rst_n,
    input logic                                alloc_grant,
    input logic                                full,
    input logic                                retire_en,
    input logic                                flush,
    input logic                                store_commit,
    input logic                                store_ack,
    input logic [rob_pkg::max_tag_bits-1:0]    store_tag
);

    // no grant can refill a table that nothing has drained
    full_holds_until_retire: assert property (@(posedge clk) disable iff (!rst_n)
        (full && !retire_en) |=> (full && !alloc_grant))
        else $error("full dropped or grant given without a retire");

    // a waiting store keeps the head
    store_waits_for_ack: assert property (@(posedge clk) disable iff (!rst_n)
        (store_commit && !store_ack) |=> (store_commit && $stable(store_tag)))
        else $error("store left the head without an ack");

    flush_empties_table: assert property (@(posedge clk) disable iff (!rst_n)
        flush |=> (!retire_en && !store_commit && !full))
        else $error("entries survived a flush");

endmodule

bind rob_retire_top rob_retire_sva rob_retire_sva_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .alloc_grant  (alloc_grant),
    .full         (full),
    .retire_en    (retire_en),
    .flush        (flush),
    .store_commit (store_commit),
    .store_ack    (store_ack),
    .store_tag    (store_tag)
);

//--- sim/tb_rob_retire.sv
`timescale 1ns/1ps

module tb_rob_retire;

    localparam int rob_depth   = 16;
    localparam int num_ops     = 2000;
    localparam int fill_cycles = rob_depth + 6;
    localparam longint watchdog_ns = longint'(num_ops) * 40 * 8;

    typedef logic [rob_pkg::max_tag_bits-1:0] tag_t;
    typedef logic [rob_pkg::reg_bits-1:0]     reg_idx_t;
    typedef logic [rob_pkg::xlen-1:0]         word_t;

    logic                  clk;
    logic                  rst_n;
    logic                  alloc_en;
    rob_pkg::alloc_req_t   alloc;
    logic                  alloc_grant;
    tag_t                  alloc_tag;
    logic                  full;
    rob_pkg::exec_result_t exec;
    logic                  store_ack;
    logic                  store_commit;
    tag_t                  store_tag;
    rob_pkg::retire_t      retire;
    rob_pkg::redirect_t    redirect;
    reg_idx_t              query_reg;
    word_t                 query_data;
    logic                  query_busy;
    tag_t                  query_tag;

    // reference model keeps program order of live tags plus per-tag fields
    tag_t              order[$];
    rob_pkg::op_kind_t m_kind   [rob_depth];
    reg_idx_t          m_rd     [rob_depth];
    logic              m_pred   [rob_depth];
    logic              m_done   [rob_depth];
    logic              m_taken  [rob_depth];
    word_t             m_data   [rob_depth];
    word_t             m_target [rob_depth];
    word_t             m_regs   [32];
    logic              m_busy   [32];
    tag_t              m_tags   [32];
    tag_t              m_tail;
    logic [31:0]       lfsr;

    rob_retire_top #(
        .rob_depth (rob_depth)
    ) rob_retire_top_inst (.*);

    always #20 clk = ~clk;

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    task automatic report_fail(input string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            report_fail($sformatf("Fail %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_tag(input string name, input tag_t got, input tag_t exp);
        if (got !== exp) begin
            report_fail($sformatf("Fail %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_retire(input rob_pkg::retire_t got, input rob_pkg::retire_t exp);
        if (exp.valid ? (got !== exp) : (got.valid !== 1'b0)) begin
            report_fail($sformatf(
                "Fail retire valid/rd/data/tag got %h/%h/%h/%h expected %h/%h/%h/%h",
                got.valid, got.rd, got.data, got.tag, exp.valid, exp.rd, exp.data, exp.tag));
        end
    endtask

    task automatic check_redirect(input rob_pkg::redirect_t got, input rob_pkg::redirect_t exp);
        if (exp.valid ? (got !== exp) : (got.valid !== 1'b0)) begin
            report_fail($sformatf("Fail redirect valid/pc got %h/%h expected %h/%h",
                got.valid, got.pc, exp.valid, exp.pc));
        end
    endtask

    task automatic check_query(input word_t got_data, input logic got_busy, input tag_t got_tag,
                               input word_t exp_data, input logic exp_busy, input tag_t exp_tag);
        if (got_data !== exp_data || got_busy !== exp_busy || got_tag !== exp_tag) begin
            report_fail($sformatf("Fail query x%0d data/busy/tag got %h/%h/%h expected %h/%h/%h",
                query_reg, got_data, got_busy, got_tag, exp_data, exp_busy, exp_tag));
        end
    endtask

    initial begin
        rob_pkg::retire_t      exp_ret;
        rob_pkg::redirect_t    exp_red;
        rob_pkg::alloc_req_t   n_alloc;
        rob_pkg::exec_result_t n_exec;
        logic                  n_alloc_en;
        logic                  n_ack;
        tag_t                  head;
        logic                  head_store;
        logic                  exp_grant;
        logic                  filling;
        int                    grants;
        int                    n_retire;
        int                    n_redirect;
        int                    n_store;
        int                    n_pending;
        int                    pick;

        lfsr      = 32'h13e39340;
        clk       = 1'b0;
        rst_n     = 1'b0;
        alloc_en  = 1'b0;
        alloc     = '0;
        exec      = '0;
        store_ack = 1'b0;
        query_reg = '0;
        m_tail    = '0;
        for (int i = 0; i < 32; i++) begin
            m_regs[i] = '0;
            m_busy[i] = 1'b0;
            m_tags[i] = '0;
        end
        for (int i = 0; i < rob_depth; i++) begin
            m_done[i] = 1'b0;
        end
        grants     = 0;
        n_retire   = 0;
        n_redirect = 0;
        n_store    = 0;

        repeat (8) @(posedge clk);
        rst_n <= 1'b1;

        for (int cyc = 0; cyc < fill_cycles + num_ops; cyc++) begin
            @(negedge clk);
            // predict the head decision from model state and applied inputs
            exp_ret    = '0;
            exp_red    = '0;
            head       = '0;
            head_store = 1'b0;
            if (order.size() != 0) begin
                head          = order[0];
                head_store    = (m_kind[head] == rob_pkg::kind_store);
                exp_ret.valid = head_store ? store_ack : m_done[head];
                exp_ret.rd    = head_store ? '0 : m_rd[head];
                exp_ret.data  = m_data[head];
                exp_ret.tag   = head;
                exp_red.valid = exp_ret.valid && (m_kind[head] == rob_pkg::kind_branch)
                                && (m_pred[head] != m_taken[head]);
                exp_red.pc    = m_target[head];
            end
            exp_grant = alloc_en && (order.size() < rob_depth) && !exp_red.valid;

            check_flag("alloc_grant", alloc_grant, exp_grant);
            check_tag("alloc_tag", alloc_tag, m_tail);
            check_flag("full", full, order.size() == rob_depth);
            check_flag("store_commit", store_commit, head_store);
            if (head_store) begin
                check_tag("store_tag", store_tag, head);
            end
            check_retire(retire, exp_ret);
            check_redirect(redirect, exp_red);
            check_query(query_data, query_busy, query_tag,
                        m_regs[query_reg], m_busy[query_reg], m_tags[query_reg]);

            if (cyc < fill_cycles && exp_grant) begin
                grants++;
            end
            if (cyc == fill_cycles - 1 && grants != rob_depth) begin
                report_fail($sformatf("Fail grant_count got %h expected %h", grants, rob_depth));
            end

            // advance the model across the coming edge
            if (exp_ret.valid) begin
                n_retire++;
            end
            if (exp_red.valid) begin
                n_redirect++;
                if (m_rd[head] != '0) begin
                    m_regs[m_rd[head]] = m_data[head];
                end
                order.delete();
                for (int i = 0; i < 32; i++) begin
                    m_busy[i] = 1'b0;
                end
                for (int i = 0; i < rob_depth; i++) begin
                    m_done[i] = 1'b0;
                end
                m_tail = '0;
            end else begin
                if (exec.valid) begin
                    m_done[exec.tag]   = 1'b1;
                    m_data[exec.tag]   = exec.data;
                    m_taken[exec.tag]  = exec.taken;
                    m_target[exec.tag] = exec.target;
                end
                if (exp_ret.valid) begin
                    order.delete(0);
                    m_done[head] = 1'b0;
                    if (head_store) begin
                        n_store++;
                    end else if (m_rd[head] != '0) begin
                        m_regs[m_rd[head]] = m_data[head];
                        // a newer rename keeps the register busy
                        if (m_busy[m_rd[head]] && m_tags[m_rd[head]] == head) begin
                            m_busy[m_rd[head]] = 1'b0;
                        end
                    end
                end
                if (exp_grant) begin
                    order.push_back(m_tail);
                    m_kind[m_tail] = alloc.kind;
                    m_rd[m_tail]   = alloc.rd;
                    m_pred[m_tail] = alloc.pred_taken;
                    m_done[m_tail] = 1'b0;
                    if (alloc.rd != '0) begin
                        m_busy[alloc.rd] = 1'b1;
                        m_tags[alloc.rd] = m_tail;
                    end
                    m_tail = (m_tail == tag_t'(rob_depth - 1)) ? '0 : m_tail + 1'b1;
                end
            end

            // fill phase withholds completions and acks
            filling    = (cyc + 1 < fill_cycles);
            n_alloc_en = alloc_en;
            n_alloc    = alloc;
            if (!alloc_en || exp_grant) begin
                n_alloc_en = filling || (rand_bits(2) != 0);
                case (rand_bits(2))
                    32'd1:   n_alloc.kind = rob_pkg::kind_branch;
                    32'd2:   n_alloc.kind = rob_pkg::kind_store;
                    default: n_alloc.kind = rob_pkg::kind_alu;
                endcase
                n_alloc.rd         = reg_idx_t'(rand_bits(5));
                n_alloc.pred_taken = rand_bits(1) != 0;
            end

            n_exec    = '0;
            n_pending = 0;
            foreach (order[i]) begin
                if (!m_done[order[i]]) begin
                    n_pending++;
                end
            end
            if (!filling && n_pending != 0 && rand_bits(2) != 0) begin
                pick = int'(rand_bits(8) % n_pending);
                foreach (order[i]) begin
                    if (!m_done[order[i]]) begin
                        if (pick == 0) begin
                            n_exec.tag = order[i];
                        end
                        pick--;
                    end
                end
                n_exec.valid  = 1'b1;
                n_exec.data   = word_t'(rand_bits(32));
                n_exec.taken  = rand_bits(1) != 0;
                n_exec.target = word_t'(rand_bits(32));
            end

            // ack only a store whose data is already in
            n_ack = 1'b0;
            if (!filling && order.size() != 0) begin
                if (m_kind[order[0]] == rob_pkg::kind_store && m_done[order[0]]) begin
                    n_ack = rand_bits(1) != 0;
                end
            end

            @(posedge clk);
            alloc_en  <= n_alloc_en;
            alloc     <= n_alloc;
            exec      <= n_exec;
            store_ack <= n_ack;
            query_reg <= reg_idx_t'(rand_bits(5));
        end

        if (n_redirect > 0 && n_store > 0 && n_retire > num_ops / 10) begin
            $display("Testbench passed");
            $finish;
        end else begin
            $display("too few retires, store retires or redirects were seen");
            $display("Testbench failed");
            $fatal(1, "stimulus did not reach every behavior");
        end
    end

    initial begin
        #(watchdog_ns);
        $display("watchdog expired, the run hung");
        $display("Testbench failed");
        $fatal(1, "watchdog expired");
    end

endmodule

//--- tb.f
source/rob_pkg.sv
source/rob_table.sv
source/rob_commit.sv
source/reg_status.sv
source/rob_retire_top.sv
sim/rob_retire_sva.sv
sim/tb_rob_retire.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_rob_retire
FILELIST   := tb.f
BUILD_DIR  := obj_dir
SIM_FLAGS  := --binary --timing --assert -Wno-fatal --top-module $(TOP) -Mdir $(BUILD_DIR)
LINT_FLAGS := --lint-only --timing -Wall --top-module $(TOP)

SOURCES := $(shell cat $(FILELIST))

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST)

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
